// File: design/router_pkg.sv
// shared router types and port count, imported by every design and test file
package router_pkg;

    //========================================
    // port count and directions
    //========================================
    localparam int num_ports = 5;             // north, east, south, west, local

    // port index order, also the arbiter order
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    //========================================
    // tile and address
    //========================================
    // grid counts from 1, x grows east, y grows south
    //   (1,1) (2,1) (3,1)
    //   (1,2) (2,2) (3,2)
    //   (1,3) (2,3) (3,3)
    typedef struct packed {
        logic [3:0] x;                        // column
        logic [3:0] y;                        // row
    } t_tile_id;

    typedef struct packed {
        t_tile_id    tile;                    // destination tile, bits 31:24
        logic [23:0] offset;                  // location inside that tile
    } t_addr_split;

    // flat word on the fabric, tile plus offset for routing
    typedef union packed {
        logic [31:0] flat;
        t_addr_split split;
    } t_address;

    //========================================
    // request and ready
    //========================================
    typedef struct packed {
        t_address    address;
        logic [31:0] data;
        logic [1:0]  opcode;
        t_tile_id    requestor_id;            // tile that issued the request
        t_cardinal   next_tile_fifo_arb_id;   // output port to take at the tile it enters
    } t_tile_trans;                           // 77 bits

    // one bit per arbiter
    // declared local first so that bit [NORTH] is north_arb etc
    typedef struct packed {
        logic local_arb;
        logic west_arb;
        logic south_arb;
        logic east_arb;
        logic north_arb;
    } t_fab_ready;

endpackage

// File: design/hop_if.sv
// link from the route stage into the per-pair request buffers, space bits going back
`timescale 1ns/1ns

interface hop_if
    import router_pkg::*;
();

    logic        [num_ports-1:0] valid;                    // per input, request this cycle
    t_tile_trans [num_ports-1:0] req;                      // per input, next hop already rewritten
    t_cardinal   [num_ports-1:0] target;                   // per input, output it asked for
    logic        [num_ports-1:0][num_ports-1:0] space;     // [in][out], pair FIFO not full

    // route side pushes requests, sees space
    modport route_side (
        output valid,
        output req,
        output target,
        input  space
    );

    // buffer side takes requests, reports space
    modport buffer_side (
        input  valid,
        input  req,
        input  target,
        output space
    );

endinterface

// File: design/route_stage.sv
// combinational route stage: picks each input's output and rewrites its next-hop field
`timescale 1ns/1ns

module route_stage
    import router_pkg::*;
(
    input  t_tile_id                    local_tile_id,
    input  logic        [num_ports-1:0] in_valid,
    input  t_tile_trans [num_ports-1:0] in_req,
    hop_if.route_side                   hop
);

    // exit port at the neighbor reached through dir, X first then Y
    function automatic t_cardinal exit_port(
        input t_tile_id  here,
        input t_cardinal dir,
        input t_tile_id  dest
    );
        t_tile_id nbr;
        nbr = here;
        case (dir)                                   // step one tile
            NORTH:   nbr.y = here.y - 4'd1;
            EAST:    nbr.x = here.x + 4'd1;
            SOUTH:   nbr.y = here.y + 4'd1;
            WEST:    nbr.x = here.x - 4'd1;
            default: nbr   = here;
        endcase
        // x first
        if (dest.x > nbr.x) begin
            return EAST;
        end else if (dest.x < nbr.x) begin
            return WEST;
        end
        // then y
        if (dest.y > nbr.y) begin
            return SOUTH;
        end else if (dest.y < nbr.y) begin
            return NORTH;
        end
        return LOCAL;                                // arrived
    endfunction

    //========================================
    // per input decode and rewrite
    //========================================
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            hop.valid[i]  = in_valid[i];
            hop.target[i] = in_req[i].next_tile_fifo_arb_id;   // field names this tile's output
            hop.req[i]    = in_req[i];
            // local delivery keeps its field
            if (in_req[i].next_tile_fifo_arb_id != LOCAL) begin
                hop.req[i].next_tile_fifo_arb_id = exit_port(
                    local_tile_id,
                    in_req[i].next_tile_fifo_arb_id,
                    in_req[i].address.split.tile
                );
            end
        end
    end

endmodule

// File: design/request_fifo.sv
// synchronous request FIFO for one input/output pair, with full and empty levels
`timescale 1ns/1ns

module request_fifo
    import router_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  t_tile_trans wr_req,
    input  logic        pop,
    output t_tile_trans rd_req,
    output logic        not_empty,
    output logic        not_full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    t_tile_trans          mem [fifo_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic                 wr_en;
    logic                 rd_en;

    assign wr_en     = push && not_full;          // overflow never written
    assign rd_en     = pop && not_empty;
    assign not_empty = (count != '0);
    assign not_full  = (count != cnt_w'(fifo_depth));
    assign rd_req    = mem[rd_ptr];               // head, valid one cycle after the write

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_req;
        end
    end

    // pointers wrap at depth, any depth allowed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(wr_en) - cnt_w'(rd_en);   // both at once, no change
        end
    end

endmodule

// File: design/xbar_buffer.sv
// 5x5 array of request FIFOs, one per input/output pair, heads face the output arbiters
`timescale 1ns/1ns

module xbar_buffer
    import router_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    hop_if.buffer_side                                  hop,
    output logic        [num_ports-1:0][num_ports-1:0]  head_valid,  // [out][in]
    output t_tile_trans [num_ports-1:0][num_ports-1:0]  head_req,    // [out][in]
    input  logic        [num_ports-1:0][num_ports-1:0]  pop          // [out][in]
);

    logic [num_ports-1:0][num_ports-1:0] pair_space;   // [in][out]

    assign hop.space = pair_space;                     // back to the input side

    //========================================
    // one FIFO per (in, out) pair
    //========================================
    for (genvar i = 0; i < num_ports; i++) begin : g_in
        for (genvar o = 0; o < num_ports; o++) begin : g_out
            logic push;

            // input i only fills the FIFO of the output it targets
            assign push = hop.valid[i] && (hop.target[i] == t_cardinal'(o));

            request_fifo #(
                .fifo_depth (fifo_depth)
            ) u_request_fifo (
                .clk       (clk),
                .rst_n     (rst_n),
                .push      (push),
                .wr_req    (hop.req[i]),
                .pop       (pop[o][i]),            // from arbiter o
                .rd_req    (head_req[o][i]),
                .not_empty (head_valid[o][i]),
                .not_full  (pair_space[i][o])      // ready bit o of input i
            );
        end
    end

endmodule

// File: design/output_arbiter.sv
// round-robin arbiter for one output port, launches a head only when the neighbor has space
`timescale 1ns/1ns

module output_arbiter
    import router_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic        [num_ports-1:0] head_valid,   // per input, FIFO head present
    input  t_tile_trans [num_ports-1:0] head_req,
    input  t_fab_ready                  nbr_ready,    // space at the neighbor tile
    output logic        [num_ports-1:0] pop,          // one-hot, winner leaves its FIFO
    output logic                        out_valid,
    output t_tile_trans                 out_req
);

    localparam int ptr_w = $clog2(num_ports);

    logic [num_ports-1:0] eligible;
    logic [ptr_w-1:0]     ptr;                        // first input to look at
    logic [ptr_w-1:0]     grant_idx;
    logic                 grant_hit;

    //========================================
    // eligibility and winner
    //========================================
    // the neighbor FIFO is picked by the rewritten field
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            eligible[i] = head_valid[i] && nbr_ready[head_req[i].next_tile_fifo_arb_id];
        end
    end

    // first eligible input at or after ptr
    always_comb begin
        grant_hit = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < num_ports; k++) begin
            if (!grant_hit && eligible[(int'(ptr) + k) % num_ports]) begin
                grant_hit = 1'b1;
                grant_idx = ptr_w'((int'(ptr) + k) % num_ports);
            end
        end
    end

    always_comb begin
        pop = '0;
        if (grant_hit) begin
            pop[grant_idx] = 1'b1;
        end
    end

    //========================================
    // registered launch
    //========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ptr       <= '0;                           // north first
        end else begin
            out_valid <= grant_hit;                    // one pulse per launch
            if (grant_hit) begin
                // one past the winner, wraps after local
                ptr <= (grant_idx == ptr_w'(num_ports - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    // payload only, qualified by out_valid
    always_ff @(posedge clk) begin
        if (grant_hit) begin
            out_req <= head_req[grant_idx];
        end
    end

endmodule

// File: design/router_top.sv
// five-port mesh-tile router top: per-direction ports around route, buffer and arbiter stages
`timescale 1ns/1ns

module router_top
    import router_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    //========================================
    // north
    //========================================
    input  logic        in_north_req_valid,
    input  t_tile_trans in_north_req,
    output t_fab_ready  out_north_ready,      // our pair FIFOs fed from north
    output logic        out_north_req_valid,
    output t_tile_trans out_north_req,
    input  t_fab_ready  in_north_ready,       // space in the north tile
    //========================================
    // east
    //========================================
    input  logic        in_east_req_valid,
    input  t_tile_trans in_east_req,
    output t_fab_ready  out_east_ready,
    output logic        out_east_req_valid,
    output t_tile_trans out_east_req,
    input  t_fab_ready  in_east_ready,
    //========================================
    // south
    //========================================
    input  logic        in_south_req_valid,
    input  t_tile_trans in_south_req,
    output t_fab_ready  out_south_ready,
    output logic        out_south_req_valid,
    output t_tile_trans out_south_req,
    input  t_fab_ready  in_south_ready,
    //========================================
    // west
    //========================================
    input  logic        in_west_req_valid,
    input  t_tile_trans in_west_req,
    output t_fab_ready  out_west_ready,
    output logic        out_west_req_valid,
    output t_tile_trans out_west_req,
    input  t_fab_ready  in_west_ready,
    //========================================
    // local core
    //========================================
    input  logic        in_local_req_valid,
    input  t_tile_trans in_local_req,
    output t_fab_ready  out_local_ready,
    output logic        out_local_req_valid,
    output t_tile_trans out_local_req,
    input  t_fab_ready  in_local_ready
);

    // port vectors, index is t_cardinal
    logic        [num_ports-1:0]                 in_valid;
    t_tile_trans [num_ports-1:0]                 in_req;
    t_fab_ready  [num_ports-1:0]                 nbr_ready;
    logic        [num_ports-1:0]                 out_valid;
    t_tile_trans [num_ports-1:0]                 out_req;
    logic        [num_ports-1:0][num_ports-1:0]  head_valid;   // [out][in]
    t_tile_trans [num_ports-1:0][num_ports-1:0]  head_req;
    logic        [num_ports-1:0][num_ports-1:0]  pop;

    hop_if hop ();

    assign in_valid  = {in_local_req_valid, in_west_req_valid, in_south_req_valid,
                        in_east_req_valid, in_north_req_valid};
    assign in_req    = {in_local_req, in_west_req, in_south_req, in_east_req, in_north_req};
    assign nbr_ready = {in_local_ready, in_west_ready, in_south_ready, in_east_ready,
                        in_north_ready};

    // row of the space matrix per input, bit per arbiter
    assign out_north_ready = hop.space[NORTH];
    assign out_east_ready  = hop.space[EAST];
    assign out_south_ready = hop.space[SOUTH];
    assign out_west_ready  = hop.space[WEST];
    assign out_local_ready = hop.space[LOCAL];

    assign {out_local_req_valid, out_west_req_valid, out_south_req_valid,
            out_east_req_valid, out_north_req_valid} = out_valid;
    assign {out_local_req, out_west_req, out_south_req, out_east_req, out_north_req} = out_req;

    route_stage u_route_stage (
        .local_tile_id (local_tile_id),
        .in_valid      (in_valid),
        .in_req        (in_req),
        .hop           (hop)
    );

    xbar_buffer #(
        .fifo_depth (fifo_depth)
    ) u_xbar_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .hop        (hop),
        .head_valid (head_valid),
        .head_req   (head_req),
        .pop        (pop)
    );

    // one arbiter per output port
    for (genvar o = 0; o < num_ports; o++) begin : g_arb
        output_arbiter u_output_arbiter (
            .clk        (clk),
            .rst_n      (rst_n),
            .head_valid (head_valid[o]),
            .head_req   (head_req[o]),
            .nbr_ready  (nbr_ready[o]),
            .pop        (pop[o]),
            .out_valid  (out_valid[o]),
            .out_req    (out_req[o])
        );
    end

endmodule

// File: test/router_sva.sv
// bound checks on the router: idle after reset, sender ready rule, neighbor space at launch
`timescale 1ns/1ns

module router_sva
    import router_pkg::*;
(
    input logic                        clk,
    input logic                        rst_n,
    input logic        [num_ports-1:0] in_valid,
    input t_tile_trans [num_ports-1:0] in_req,
    input t_fab_ready  [num_ports-1:0] nbr_ready,
    input logic        [num_ports-1:0] out_valid,
    input t_tile_trans [num_ports-1:0] out_req,
    input t_fab_ready                  out_north_ready,
    input t_fab_ready                  out_east_ready,
    input t_fab_ready                  out_south_ready,
    input t_fab_ready                  out_west_ready,
    input t_fab_ready                  out_local_ready
);

    t_fab_ready [num_ports-1:0] own_ready;       // our pair space, per input
    t_fab_ready [num_ports-1:0] nbr_ready_q;     // space the arbiter saw at the launch edge

    assign own_ready = {out_local_ready, out_west_ready, out_south_ready,
                        out_east_ready, out_north_ready};

    always_ff @(posedge clk) begin
        nbr_ready_q <= nbr_ready;
    end

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        // reset edge leaves the port idle and all its pair FIFOs empty
        a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid[p] && own_ready[p] == '1)
            else $error("port %0d not idle after a reset edge", p);

        a_sender_ready: assert property (@(posedge clk) disable iff (!rst_n)
            in_valid[p] |-> own_ready[p][in_req[p].next_tile_fifo_arb_id])
            else $error("input %0d valid while its ready bit for the target is low", p);

        a_launch_space: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[p] |-> nbr_ready_q[p][out_req[p].next_tile_fifo_arb_id])
            else $error("output %0d launched without space at the neighbor", p);
    end

endmodule

// File: test/router_tb.sv
// router testbench: reset state, file-driven routing cases, back-pressure and contention
`timescale 1ns/1ns

module router_tb
    import router_pkg::*;
();

    localparam int fifo_depth     = 4;
    localparam int timeout_cycles = 60;

    logic                             clk;
    logic                             rst_n;
    t_tile_id                         local_tile_id;
    logic        [num_ports-1:0]      in_valid;
    t_tile_trans [num_ports-1:0]      in_req;
    t_fab_ready  [num_ports-1:0]      nbr_ready;   // space the neighbors report
    wire t_fab_ready  [num_ports-1:0] own_ready;   // DUT pair space, per input
    wire         [num_ports-1:0]      out_valid;
    wire t_tile_trans [num_ports-1:0] out_req;

    t_tile_trans expected_q [num_ports][$];        // scoreboard, one queue per output
    string       port_name [num_ports] = '{"north", "east", "south", "west", "local"};

    bind router_top router_sva u_router_sva (.*);

    router_top #(
        .fifo_depth (fifo_depth)
    ) u_router_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .local_tile_id       (local_tile_id),
        .in_north_req_valid  (in_valid[NORTH]),
        .in_north_req        (in_req[NORTH]),
        .out_north_ready     (own_ready[NORTH]),
        .out_north_req_valid (out_valid[NORTH]),
        .out_north_req       (out_req[NORTH]),
        .in_north_ready      (nbr_ready[NORTH]),
        .in_east_req_valid   (in_valid[EAST]),
        .in_east_req         (in_req[EAST]),
        .out_east_ready      (own_ready[EAST]),
        .out_east_req_valid  (out_valid[EAST]),
        .out_east_req        (out_req[EAST]),
        .in_east_ready       (nbr_ready[EAST]),
        .in_south_req_valid  (in_valid[SOUTH]),
        .in_south_req        (in_req[SOUTH]),
        .out_south_ready     (own_ready[SOUTH]),
        .out_south_req_valid (out_valid[SOUTH]),
        .out_south_req       (out_req[SOUTH]),
        .in_south_ready      (nbr_ready[SOUTH]),
        .in_west_req_valid   (in_valid[WEST]),
        .in_west_req         (in_req[WEST]),
        .out_west_ready      (own_ready[WEST]),
        .out_west_req_valid  (out_valid[WEST]),
        .out_west_req        (out_req[WEST]),
        .in_west_ready       (nbr_ready[WEST]),
        .in_local_req_valid  (in_valid[LOCAL]),
        .in_local_req        (in_req[LOCAL]),
        .out_local_ready     (own_ready[LOCAL]),
        .out_local_req_valid (out_valid[LOCAL]),
        .out_local_req       (out_req[LOCAL]),
        .in_local_ready      (nbr_ready[LOCAL])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                    // 20 ns period
    end

    //========================================
    // helpers
    //========================================
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s actual 0x%0h expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic t_tile_trans make_req(input logic [31:0] addr, input logic [1:0] opc,
                                             input logic [7:0] rid, input t_cardinal tgt);
        t_tile_trans r;
        r.address.flat          = addr;
        r.data                  = $urandom();      // payload, only has to come back intact
        r.opcode                = opc;
        r.requestor_id          = rid;
        r.next_tile_fifo_arb_id = tgt;             // output wanted at this tile
        return r;
    endfunction

    // queue a request on an output with the next hop it should carry there
    task automatic expect_out(input int p, input t_tile_trans req, input t_cardinal hop);
        req.next_tile_fifo_arb_id = hop;
        expected_q[p].push_back(req);
    endtask

    // one cycle, sampled at the falling edge, every launch checked against its queue
    task automatic tick();
        t_tile_trans expected_req;
        @(negedge clk);
        for (int p = 0; p < num_ports; p++) begin
            if (out_valid[p] !== 1'b0) begin
                if (expected_q[p].size() == 0) begin
                    $display("unexpected request left on the %s output", port_name[p]);
                    abort_run();
                end else begin
                    expected_req = expected_q[p].pop_front();
                    check_value({"out_", port_name[p], "_req.address"},
                                out_req[p].address.flat, expected_req.address.flat);
                    check_value({"out_", port_name[p], "_req.data"},
                                out_req[p].data, expected_req.data);
                    check_value({"out_", port_name[p], "_req.opcode"},
                                out_req[p].opcode, expected_req.opcode);
                    check_value({"out_", port_name[p], "_req.requestor_id"},
                                out_req[p].requestor_id, expected_req.requestor_id);
                    check_value({"out_", port_name[p], "_req.next_tile_fifo_arb_id"},
                                out_req[p].next_tile_fifo_arb_id,
                                expected_req.next_tile_fifo_arb_id);
                end
            end
        end
    endtask

    // tick until at most left requests wait on output p
    task automatic wait_queue(input int p, input int left);
        int waited;
        waited = 0;
        while (expected_q[p].size() > left && waited < timeout_cycles) begin
            tick();
            waited++;
        end
        if (expected_q[p].size() > left) begin
            $display("timeout: out_%s_req_valid never became valid within %0d cycles",
                     port_name[p], timeout_cycles);
            abort_run();
        end
    endtask

    task automatic drain();
        for (int p = 0; p < num_ports; p++) begin
            wait_queue(p, 0);
        end
    endtask

    // drive on input p, only while its ready bit for the target is high
    task automatic send(input int p, input t_tile_trans req);
        check_value({"out_", port_name[p], "_ready bit of the target"},
                    own_ready[p][req.next_tile_fifo_arb_id], 1'b1);
        in_valid[p] = 1'b1;
        in_req[p]   = req;
    endtask

    //========================================
    // main sequence
    //========================================
    initial begin : main_seq
        int          fd;
        int          fields;
        int          n_cases;
        int          in_p;
        int          tgt;
        int          opc;
        int          exp_out;
        int          exp_hop;
        logic [31:0] addr;
        logic [7:0]  rid;
        string       line;
        t_tile_trans req;
        t_tile_trans held [fifo_depth];

        void'($urandom(27760));
        rst_n         = 1'b0;
        local_tile_id = '{x: 4'd2, y: 4'd2};      // centre of the 3x3 grid
        in_valid      = '0;
        in_req        = '0;
        nbr_ready     = '1;
        repeat (5) @(posedge clk);

        // reset state
        @(negedge clk);
        for (int p = 0; p < num_ports; p++) begin
            check_value({"out_", port_name[p], "_req_valid"}, out_valid[p], 1'b0);
            check_value({"out_", port_name[p], "_ready"}, own_ready[p], 5'h1f);
        end
        rst_n = 1'b1;
        tick();

        // contention, pointers still at north
        req = make_req(32'h2300_0500, 2'd1, 8'h12, SOUTH);
        send(NORTH, req);
        expect_out(SOUTH, req, LOCAL);             // neighbor (2,3) is the destination
        req = make_req(32'h2300_0600, 2'd2, 8'h32, SOUTH);
        send(WEST, req);
        expect_out(SOUTH, req, LOCAL);
        tick();
        in_valid = '0;
        wait_queue(SOUTH, 1);                      // north first
        tick();
        check_value("south launches left after back to back", expected_q[SOUTH].size(), 0);
        repeat (3) tick();

        //========================================
        // routing cases from the data file
        //========================================
        fd = $fopen("test/router_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file test/router_cases.txt");
            abort_run();
        end
        n_cases = 0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%d %d %h %d %h %d %d",
                                 in_p, tgt, addr, opc, rid, exp_out, exp_hop);
                if (fields != 7) begin
                    $display("malformed line in the case file: %s", line);
                    abort_run();
                end
                req = make_req(addr, 2'(opc), rid, t_cardinal'(tgt));
                send(in_p, req);
                expect_out(exp_out, req, t_cardinal'(exp_hop));
                tick();
                in_valid = '0;
                drain();
                repeat (3) tick();                 // a second copy would show here
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("the case file held no cases");
            abort_run();
        end

        //========================================
        // back-pressure on east, local_arb bit
        //========================================
        nbr_ready[EAST].local_arb = 1'b0;
        for (int k = 0; k < fifo_depth; k++) begin
            held[k] = make_req(32'h3200_0700 + k, 2'd3, 8'h22, EAST);   // stops at (3,2)
            send(LOCAL, held[k]);
            tick();
        end
        in_valid = '0;
        check_value("out_local_ready.east_arb", own_ready[LOCAL].east_arb, 1'b0);

        // a head for another pair passes the blocked ones
        req = make_req(32'h3100_0800, 2'd0, 8'h12, EAST);
        send(NORTH, req);
        expect_out(EAST, req, NORTH);
        tick();
        in_valid = '0;
        drain();

        repeat (20) tick();                        // nothing may leave east here
        check_value("out_local_ready.east_arb", own_ready[LOCAL].east_arb, 1'b0);

        nbr_ready[EAST].local_arb = 1'b1;
        for (int k = 0; k < fifo_depth; k++) begin
            expect_out(EAST, held[k], LOCAL);      // arrival order
        end
        drain();
        repeat (3) tick();
        check_value("out_local_ready.east_arb", own_ready[LOCAL].east_arb, 1'b1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sim.f
design/router_pkg.sv
design/hop_if.sv
design/route_stage.sv
design/request_fifo.sv
design/xbar_buffer.sv
design/output_arbiter.sv
design/router_top.sv
test/router_sva.sv
test/router_tb.sv

// File: test/router_cases.txt
# in tgt address opc rid exp_out exp_hop ; ports 0 north 1 east 2 south 3 west 4 local
# address in hex with destination tile x,y in the top byte, rid a hex tile id, router at (2,2)
4 0 21000010 0 22 0 4
4 0 31000020 1 22 0 1
4 0 13000030 2 22 0 3
4 0 23000040 3 22 0 2
2 1 32001000 0 23 1 4
3 1 31002000 1 12 1 0
0 1 33003000 2 21 1 2
4 1 11004000 3 22 1 3
0 2 23010000 0 21 2 4
3 2 13020000 1 12 2 3
1 2 31030000 2 32 2 1
4 2 21040000 3 22 2 0
1 3 12100000 0 32 3 4
2 3 11200000 1 23 3 0
4 3 13300000 2 22 3 2
0 3 33400000 3 21 3 1
0 4 22abcdef 0 21 4 4
1 4 22123456 1 32 4 4
2 2 23ffffff 2 23 2 4
1 1 32000001 3 32 1 4
